// ==== bench/iccm_mem_tb.sv ====
//**************************************************************************
// Self-checking testbench for the instruction CCM. Builds a table of word
// writes, double-word writes, corrections and reads, works out the
// expected read data from a shadow memory and a two-row redundancy model,
// then applies the table in a loop and compares every read.
//**************************************************************************
`timescale 1ns/1ps

module iccm_mem_tb
   import iccm_pkg::*;
();

   localparam int max_ops      = 64;
   localparam int reset_cycles = 10;

   // Operation kinds
   localparam logic [2:0] op_wr_word  = 3'd0;
   localparam logic [2:0] op_wr_dword = 3'd1;
   localparam logic [2:0] op_correct  = 3'd2;
   localparam logic [2:0] op_read     = 3'd3;
   localparam logic [2:0] op_rd_pair  = 3'd4;   // Read with the double-word step

   logic               clk;
   logic               rst_n;
   logic               rden;
   logic               wren;
   iccm_addr_u         rw_addr;
   logic [2:0]         wr_size;
   logic [dword_w-1:0] wr_data;
   logic               buf_correct_ecc;
   logic               correction_state;
   logic [rd_w-1:0]    rd_data;
   logic [dword_w-1:0] rd_data_ecc;

   //**************************************************************************
   // Stimulus table and reference model state
   //**************************************************************************
   logic [2:0]         op_kind [max_ops];
   iccm_addr_u         op_addr [max_ops];
   logic [dword_w-1:0] op_data [max_ops];
   logic               op_cs   [max_ops];
   logic [rd_w-1:0]    exp_rd  [max_ops];
   logic [dword_w-1:0] exp_ecc [max_ops];
   int                 num_ops     = 0;
   logic               table_ready = 1'b0;

   logic [word_w-1:0]  shadow [1 << tag_w];   // One word per word address
   logic [num_red-1:0] m_valid = '0;
   logic [tag_w-1:0]   m_tag  [num_red];
   logic [word_w-1:0]  m_data [num_red];
   logic               m_lru = 1'b0;

   int check_count = 0;
   int err_count   = 0;

   iccm_mem uut (
      .clk              (clk),
      .rst_n            (rst_n),
      .rden             (rden),
      .wren             (wren),
      .rw_addr          (rw_addr),
      .wr_size          (wr_size),
      .wr_data          (wr_data),
      .buf_correct_ecc  (buf_correct_ecc),
      .correction_state (correction_state),
      .rd_data          (rd_data),
      .rd_data_ecc      (rd_data_ecc)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [word_w-1:0] rand_word();
      logic [word_w-1:0] w;
      w[data_w-1:0]      = $urandom();
      w[word_w-1:data_w] = (word_w - data_w)'($urandom());
      return w;
   endfunction

   function automatic iccm_addr_u make_addr(input int row, input int bank, input logic half);
      iccm_addr_u a;
      a.bank_view.row  = row_w'(row);
      a.bank_view.bank = bank_idx_w'(bank);
      a.bank_view.half = half;
      return a;
   endfunction

   // Odd banks hold the upper word of the write data
   function automatic logic [word_w-1:0] bank_half(input logic [tag_w-1:0] tag,
                                                   input logic [dword_w-1:0] data);
      return tag[0] ? data[dword_w-1:word_w] : data[word_w-1:0];
   endfunction

   // A valid redundant row stands in for the bank word
   function automatic logic [word_w-1:0] lookup_word(input logic [tag_w-1:0] tag);
      logic [word_w-1:0] w;
      w = shadow[tag];
      for (int r = 0; r < num_red; r++) begin
         if (m_valid[r] && m_tag[r] == tag) w = m_data[r];
      end
      return w;
   endfunction

   function automatic string op_name(input logic [2:0] kind);
      case (kind)
         op_wr_word:  return "word write";
         op_wr_dword: return "double-word write";
         op_correct:  return "correction";
         op_rd_pair:  return "pair read";
         default:     return "read";
      endcase
   endfunction

   //**************************************************************************
   // Table entry plus the model update that gives its expected values
   //**************************************************************************
   task automatic add_op(input logic [2:0] kind, input iccm_addr_u addr,
                         input logic [dword_w-1:0] data, input logic cs);
      iccm_addr_u         addr2;
      logic [tag_w-1:0]   t1;
      logic [tag_w-1:0]   t2;
      logic [word_w-1:0]  w1;
      logic [word_w-1:0]  w2;
      logic [num_red-1:0] hits;
      int                 step;
      step  = (kind == op_wr_dword || kind == op_rd_pair) ? 2 : 1;
      addr2 = iccm_addr_u'(addr + addr_w'(step));
      t1    = addr.tag_view.tag;
      t2    = addr2.tag_view.tag;
      op_kind[num_ops] = kind;
      op_addr[num_ops] = addr;
      op_data[num_ops] = data;
      op_cs[num_ops]   = cs;
      exp_rd[num_ops]  = '0;
      exp_ecc[num_ops] = '0;
      case (kind)
         op_wr_word, op_wr_dword: begin
            shadow[t1] = bank_half(t1, data);
            shadow[t2] = bank_half(t2, data);
            for (int r = 0; r < num_red; r++) begin
               if (m_valid[r] && m_tag[r][tag_w-1:1] == t1[tag_w-1:1] &&
                   (m_tag[r][0] == t1[0] || kind == op_wr_dword)) begin
                  m_data[r] = bank_half(m_tag[r], data);
               end
            end
         end
         op_correct: begin
            m_valid[m_lru] = 1'b1;
            m_tag[m_lru]   = t1;
            m_data[m_lru]  = data[word_w-1:0];
            m_lru          = ~m_lru;
         end
         default: begin
            w1 = lookup_word(t1);
            w2 = lookup_word(t2);
            exp_ecc[num_ops] = {w2, w1};
            // Upper halfword of the first word moves to the bottom
            if (addr.bank_view.half) begin
               exp_rd[num_ops] = {{(data_w / 2){1'b0}}, w2[data_w-1:0],
                                  w1[data_w-1:data_w/2]};
            end else begin
               exp_rd[num_ops] = {w2[data_w-1:0], w1[data_w-1:0]};
            end
            for (int r = 0; r < num_red; r++) begin
               hits[r] = m_valid[r] && (m_tag[r] == t1 || m_tag[r] == t2);
            end
            if (cs && (|hits)) m_lru = hits[0];
         end
      endcase
      num_ops++;
   endtask

   task automatic build_table();
      logic [word_w-1:0] w;
      // Every bank of row 5, plus bank 0 of row 6 for the wrapping half read
      for (int b = 0; b < num_banks; b++) begin
         w = rand_word();
         add_op(op_wr_word, make_addr(5, b, 1'b0), {w, w}, 1'b0);
      end
      w = rand_word();
      add_op(op_wr_word, make_addr(6, 0, 1'b0), {w, w}, 1'b0);
      for (int b = 0; b < num_banks; b++) begin
         add_op(op_read, make_addr(5, b, 1'b0), '0, 1'b0);
      end
      add_op(op_wr_dword, make_addr(10, 0, 1'b0), {rand_word(), rand_word()}, 1'b0);
      add_op(op_wr_dword, make_addr(12, 2, 1'b0), {rand_word(), rand_word()}, 1'b0);
      add_op(op_wr_dword, make_addr(20, 3, 1'b0), {rand_word(), rand_word()}, 1'b0);
      add_op(op_rd_pair, make_addr(10, 0, 1'b0), '0, 1'b0);
      add_op(op_rd_pair, make_addr(12, 2, 1'b0), '0, 1'b0);
      add_op(op_rd_pair, make_addr(20, 3, 1'b0), '0, 1'b0);   // Into row 21
      add_op(op_read, make_addr(21, 0, 1'b0), '0, 1'b0);
      // Halfword reads across two banks
      add_op(op_read, make_addr(5, 1, 1'b1), '0, 1'b0);
      add_op(op_read, make_addr(5, 3, 1'b1), '0, 1'b0);
      add_op(op_read, make_addr(20, 3, 1'b1), '0, 1'b0);
      add_op(op_read, make_addr(10, 0, 1'b1), '0, 1'b0);
      //***********************************************************************
      // Correction, then refresh by word and double-word writes
      //***********************************************************************
      w = rand_word();
      add_op(op_wr_word, make_addr(30, 0, 1'b0), {w, w}, 1'b0);
      w = rand_word();
      add_op(op_wr_word, make_addr(30, 1, 1'b0), {w, w}, 1'b0);
      add_op(op_correct, make_addr(30, 1, 1'b0), {rand_word(), rand_word()}, 1'b0);
      add_op(op_read, make_addr(30, 1, 1'b0), '0, 1'b0);
      add_op(op_read, make_addr(30, 0, 1'b1), '0, 1'b0);
      w = rand_word();
      add_op(op_wr_word, make_addr(30, 1, 1'b0), {w, w}, 1'b0);
      add_op(op_read, make_addr(30, 1, 1'b0), '0, 1'b0);
      add_op(op_wr_dword, make_addr(30, 0, 1'b0), {rand_word(), rand_word()}, 1'b0);
      add_op(op_rd_pair, make_addr(30, 0, 1'b0), '0, 1'b0);
      // Replacement order and LRU steering
      for (int b = 0; b < 3; b++) begin
         w = rand_word();
         add_op(op_wr_word, make_addr(40 + b, (b + 2) % num_banks, 1'b0), {w, w}, 1'b0);
      end
      add_op(op_correct, make_addr(40, 2, 1'b0), {rand_word(), rand_word()}, 1'b0);
      add_op(op_correct, make_addr(41, 3, 1'b0), {rand_word(), rand_word()}, 1'b0);
      add_op(op_read, make_addr(30, 1, 1'b0), '0, 1'b0);   // Evicted, bank word
      add_op(op_read, make_addr(40, 2, 1'b0), '0, 1'b1);   // Row 1 hit, LRU to row 0
      add_op(op_correct, make_addr(42, 0, 1'b0), {rand_word(), rand_word()}, 1'b0);
      add_op(op_read, make_addr(41, 3, 1'b0), '0, 1'b0);
      add_op(op_read, make_addr(42, 0, 1'b0), '0, 1'b0);
      add_op(op_read, make_addr(40, 2, 1'b0), '0, 1'b0);
      add_op(op_read, make_addr(40, 2, 1'b0), '0, 1'b1);
      add_op(op_read, make_addr(42, 0, 1'b0), '0, 1'b1);   // Row 0 hit, LRU to row 1
      add_op(op_correct, make_addr(41, 3, 1'b0), {rand_word(), rand_word()}, 1'b0);
      add_op(op_read, make_addr(40, 2, 1'b0), '0, 1'b0);
      add_op(op_read, make_addr(41, 3, 1'b0), '0, 1'b0);
      add_op(op_read, make_addr(42, 0, 1'b0), '0, 1'b0);
   endtask

   task automatic check_data(input string sig, input logic [rd_w-1:0] expected,
                             input logic [rd_w-1:0] actual);
      check_count++;
      if (actual !== expected) begin
         err_count++;
         $display("Mismatch %s: expected 0x%h, got 0x%h", sig, expected, actual);
      end
   endtask

   task automatic check_raw(input string sig, input logic [dword_w-1:0] expected,
                            input logic [dword_w-1:0] actual);
      check_count++;
      if (actual !== expected) begin
         err_count++;
         $display("Mismatch %s: expected 0x%h, got 0x%h", sig, expected, actual);
      end
   endtask

   //**************************************************************************
   // One table entry, one cycle of stimulus, reads checked after the edge
   //**************************************************************************
   task automatic apply_op(input int i);
      int errs_before;
      errs_before = err_count;
      @(posedge clk);
      rw_addr          <= op_addr[i];
      wr_data          <= op_data[i];
      correction_state <= op_cs[i];
      wr_size          <= (op_kind[i] == op_wr_dword || op_kind[i] == op_rd_pair) ? 3'b011
                                                                                   : 3'b010;
      case (op_kind[i])
         op_wr_word, op_wr_dword: wren <= 1'b1;
         op_correct:              buf_correct_ecc <= 1'b1;
         default:                 rden <= 1'b1;
      endcase
      @(posedge clk);
      rden             <= 1'b0;
      wren             <= 1'b0;
      buf_correct_ecc  <= 1'b0;
      correction_state <= 1'b0;
      if (op_kind[i] == op_read || op_kind[i] == op_rd_pair) begin
         @(negedge clk);
         check_data("rd_data", exp_rd[i], rd_data);
         check_raw("rd_data_ecc", exp_ecc[i], rd_data_ecc);
      end
      $display("Test %0d: %s at byte 0x%h %s", i, op_name(op_kind[i]), {op_addr[i], 1'b0},
               (err_count == errs_before) ? "ok" : "failed");
   endtask

   initial begin
      rst_n            = 1'b0;
      rden             = 1'b0;
      wren             = 1'b0;
      rw_addr          = '0;
      wr_size          = 3'b010;
      wr_data          = '0;
      buf_correct_ecc  = 1'b0;
      correction_state = 1'b0;
      void'($urandom(32'hb1e0_be58));
      build_table();
      table_ready = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < num_ops; i++) begin
         apply_op(i);
      end
      $display("Operations: %0d, checks: %0d, errors: %0d", num_ops, check_count, err_count);
      if (err_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // Four cycles per table entry is well above what one entry takes
   initial begin
      wait (table_ready);
      repeat (reset_cycles + num_ops * 4) @(posedge clk);
      $display("Timeout: table of %0d entries did not finish in time", num_ops);
      $display("** FAIL **");
      $finish;
   end

endmodule

// ==== common/iccm_pkg.sv ====
//**************************************************************************
// Shared sizes and the address type of the 1 KiB instruction CCM.
// The memory is four word-interleaved banks of 64 rows, each word holding
// 32 data bits and 7 check bits. Modules pull these in with a wildcard
// import in their headers.
//**************************************************************************

package iccm_pkg;

   //**************************************************************************
   // Bank geometry
   //**************************************************************************
   localparam int num_banks  = 4;
   localparam int bank_idx_w = 2;
   localparam int row_w      = 6;
   localparam int bank_rows  = 64;

   // Word widths
   localparam int word_w  = 39;       // Data plus check bits
   localparam int data_w  = 32;
   localparam int dword_w = 78;       // Two stored words
   localparam int rd_w    = 64;       // Two data parts

   //**************************************************************************
   // Addressing
   //**************************************************************************
   localparam int addr_w = 9;         // Halfword address, byte bits 9 to 1
   localparam int tag_w  = 8;         // Word address

   localparam logic [1:0] size_dword = 2'b11;

   // Redundant rows for failing locations
   localparam int num_red = 2;

   // Halfword address seen by bank control and by the redundancy tags
   typedef union packed {
      struct packed {
         logic [row_w-1:0]      row;
         logic [bank_idx_w-1:0] bank;
         logic                  half;
      } bank_view;
      struct packed {
         logic [tag_w-1:0] tag;     // Row and bank together
         logic             half;
      } tag_view;
   } iccm_addr_u;

endpackage

// ==== iccm/iccm_bank_ctrl.sv ====
//**************************************************************************
// Combinational bank control. Finds the second address of an access,
// enables the one or two banks it touches and hands each bank its row and
// its half of the write data.
//**************************************************************************
`timescale 1ns/1ps

module iccm_bank_ctrl
   import iccm_pkg::*;
(
   input  logic                              rden,
   input  logic                              wren,
   input  iccm_addr_u                        rw_addr,
   input  logic [2:0]                        wr_size,
   input  logic [dword_w-1:0]                wr_data,
   output iccm_addr_u                        addr_inc,
   output logic [num_banks-1:0]              bank_we,
   output logic [num_banks-1:0]              bank_me,
   output logic [num_banks-1:0][row_w-1:0]   bank_row,
   output logic [num_banks-1:0][word_w-1:0]  bank_wdata
);

   logic [1:0]           addr_step;
   logic [num_banks-1:0] sel_first;
   logic [num_banks-1:0] sel_second;

   // Double words step two halfwords, everything else one
   assign addr_step = (wr_size[1:0] == size_dword) ? 2'd2 : 2'd1;
   assign addr_inc  = iccm_addr_u'(rw_addr + addr_w'(addr_step));

   for (genvar i = 0; i < num_banks; i++) begin : g_bank
      assign sel_first[i]  = (rw_addr.bank_view.bank == bank_idx_w'(i));
      assign sel_second[i] = (addr_inc.bank_view.bank == bank_idx_w'(i));

      assign bank_we[i] = wren & (sel_first[i] | sel_second[i]);
      assign bank_me[i] = (wren | rden) & (sel_first[i] | sel_second[i]);

      // Carry into the next row when the second word wraps past bank 3
      assign bank_row[i] = (sel_second[i] & ~sel_first[i]) ? addr_inc.bank_view.row
                                                            : rw_addr.bank_view.row;

      // Even banks take the lower word, odd banks the upper
      if (i % 2 == 0) begin : g_even
         assign bank_wdata[i] = wr_data[word_w-1:0];
      end else begin : g_odd
         assign bank_wdata[i] = wr_data[dword_w-1:word_w];
      end
   end

endmodule

// ==== iccm/iccm_mem.sv ====
//**************************************************************************
// Top of the instruction CCM. Ties bank control, the four SRAM banks, the
// redundant rows and the read alignment together. Reads return data one
// cycle after rden, writes land at the next clock edge.
//**************************************************************************
`timescale 1ns/1ps

module iccm_mem
   import iccm_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               rden,
   input  logic               wren,
   input  iccm_addr_u         rw_addr,
   input  logic [2:0]         wr_size,
   input  logic [dword_w-1:0] wr_data,
   input  logic               buf_correct_ecc,    // Correction cycle
   input  logic               correction_state,   // Correction under way
   output logic [rd_w-1:0]    rd_data,
   output logic [dword_w-1:0] rd_data_ecc
);

   iccm_addr_u                         addr_inc;
   logic [num_banks-1:0]               bank_we;
   logic [num_banks-1:0]               bank_me;
   logic [num_banks-1:0][row_w-1:0]    bank_row;
   logic [num_banks-1:0][word_w-1:0]   bank_wdata;
   logic [num_banks-1:0][word_w-1:0]   bank_rdata;
   logic [num_red-1:0][num_banks-1:0]  red_hit_q;
   logic [num_red-1:0][word_w-1:0]     red_data;

   iccm_bank_ctrl u_bank_ctrl (
      .rden       (rden),
      .wren       (wren),
      .rw_addr    (rw_addr),
      .wr_size    (wr_size),
      .wr_data    (wr_data),
      .addr_inc   (addr_inc),
      .bank_we    (bank_we),
      .bank_me    (bank_me),
      .bank_row   (bank_row),
      .bank_wdata (bank_wdata)
   );

   for (genvar i = 0; i < num_banks; i++) begin : g_bank
      iccm_sram_bank u_bank (
         .clk   (clk),
         .me    (bank_me[i]),
         .we    (bank_we[i]),
         .row   (bank_row[i]),
         .wdata (bank_wdata[i]),
         .rdata (bank_rdata[i])
      );
   end

   iccm_redundancy u_redundancy (
      .clk              (clk),
      .rst_n            (rst_n),
      .rden             (rden),
      .wren             (wren),
      .rw_addr          (rw_addr),
      .addr_inc         (addr_inc),
      .wr_size          (wr_size),
      .wr_data          (wr_data),
      .buf_correct_ecc  (buf_correct_ecc),
      .correction_state (correction_state),
      .red_hit_q        (red_hit_q),
      .red_data         (red_data)
   );

   iccm_rd_align u_rd_align (
      .clk         (clk),
      .rst_n       (rst_n),
      .rden        (rden),
      .rw_addr     (rw_addr),
      .addr_inc    (addr_inc),
      .bank_rdata  (bank_rdata),
      .red_hit_q   (red_hit_q),
      .red_data    (red_data),
      .rd_data     (rd_data),
      .rd_data_ecc (rd_data_ecc)
   );

endmodule

// ==== iccm/iccm_rd_align.sv ====
//**************************************************************************
// Read alignment. Remembers which banks a read touched, swaps in redundant
// words on a hit and builds the raw and the halfword-aligned outputs.
// Outputs follow the bank registers with no added delay.
//**************************************************************************
`timescale 1ns/1ps

module iccm_rd_align
   import iccm_pkg::*;
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              rden,
   input  iccm_addr_u                        rw_addr,
   input  iccm_addr_u                        addr_inc,
   input  logic [num_banks-1:0][word_w-1:0]  bank_rdata,
   input  logic [num_red-1:0][num_banks-1:0] red_hit_q,
   input  logic [num_red-1:0][word_w-1:0]    red_data,
   output logic [rd_w-1:0]                   rd_data,
   output logic [dword_w-1:0]                rd_data_ecc
);

   logic [bank_idx_w-1:0]             lo_bank_q;   // Bank of rw_addr
   logic [bank_idx_w-1:0]             hi_bank_q;   // Bank of addr_inc
   logic                              half_q;
   logic [num_banks-1:0][word_w-1:0]  bank_fn;
   logic [rd_w-1:0]                   rd_pre;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lo_bank_q <= '0;
         hi_bank_q <= '0;
         half_q    <= 1'b0;
      end else if (rden) begin
         lo_bank_q <= rw_addr.bank_view.bank;
         hi_bank_q <= addr_inc.bank_view.bank;
         half_q    <= rw_addr.bank_view.half;
      end
   end

   // Redundant rows override the bank word
   for (genvar b = 0; b < num_banks; b++) begin : g_bank
      assign bank_fn[b] = red_hit_q[1][b] ? red_data[1] :
                          red_hit_q[0][b] ? red_data[0] :
                                            bank_rdata[b];
   end

   assign rd_data_ecc = {bank_fn[hi_bank_q], bank_fn[lo_bank_q]};

   //*************************************************************************
   // Data parts only, shifted down a halfword when needed
   //*************************************************************************
   assign rd_pre  = {bank_fn[hi_bank_q][data_w-1:0], bank_fn[lo_bank_q][data_w-1:0]};
   assign rd_data = half_q ? (rd_pre >> (data_w / 2)) : rd_pre;   // Zero fill on top

endmodule

// ==== iccm/iccm_sram_bank.sv ====
//**************************************************************************
// Behavioral single-port synchronous SRAM bank, 64 rows of 39 bits.
// A write or a read happens when me is set. The read register keeps its
// value while the bank is idle or writing.
//**************************************************************************
`timescale 1ns/1ps

module iccm_sram_bank
   import iccm_pkg::*;
(
   input  logic              clk,
   input  logic              me,       // Macro enable
   input  logic              we,
   input  logic [row_w-1:0]  row,
   input  logic [word_w-1:0] wdata,
   output logic [word_w-1:0] rdata
);

   logic [word_w-1:0] mem [bank_rows];

   always_ff @(posedge clk) begin
      if (me) begin
         if (we) begin
            mem[row] <= wdata;
         end else begin
            rdata <= mem[row];   // Registered read
         end
      end
   end

endmodule

// ==== iccm_mem.f ====
common/iccm_pkg.sv
iccm/iccm_bank_ctrl.sv
iccm/iccm_sram_bank.sv
redundancy/iccm_redundancy.sv
iccm/iccm_rd_align.sv
iccm/iccm_mem.sv
bench/iccm_mem_tb.sv

// ==== redundancy/iccm_redundancy.sv ====
//**************************************************************************
// Two redundant word rows that stand in for failing bank locations.
// A correction cycle loads the row named by the LRU bit, later writes to
// the same word keep it current. Hit flags per bank are registered on
// reads and steer the read path.
//**************************************************************************
`timescale 1ns/1ps

module iccm_redundancy
   import iccm_pkg::*;
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              rden,
   input  logic                              wren,
   input  iccm_addr_u                        rw_addr,
   input  iccm_addr_u                        addr_inc,
   input  logic [2:0]                        wr_size,
   input  logic [dword_w-1:0]                wr_data,
   input  logic                              buf_correct_ecc,
   input  logic                              correction_state,
   output logic [num_red-1:0][num_banks-1:0] red_hit_q,
   output logic [num_red-1:0][word_w-1:0]    red_data
);

   logic [num_red-1:0]                 red_valid;
   logic [num_red-1:0][tag_w-1:0]      red_tag;
   logic                               red_lru;    // Row to replace next

   logic [num_red-1:0][num_banks-1:0]  red_hit;
   logic [num_red-1:0]                 red_alloc;
   logic [num_red-1:0]                 red_refresh;
   logic [num_red-1:0][word_w-1:0]     red_data_in;
   logic                               is_dword;
   logic                               lru_en;
   logic                               lru_in;

   assign is_dword = (wr_size[1:0] == size_dword);

   for (genvar r = 0; r < num_red; r++) begin : g_row

      //***********************************************************************
      // Row update
      //***********************************************************************
      assign red_alloc[r] = buf_correct_ecc & (red_lru == 1'(r));

      // Same double-word pair, and same word unless the write covers both
      assign red_refresh[r] = wren & red_valid[r] &
                              (rw_addr.tag_view.tag[tag_w-1:1] == red_tag[r][tag_w-1:1]) &
                              ((rw_addr.tag_view.tag[0] == red_tag[r][0]) | is_dword);

      // Corrected word always sits in the lower half
      assign red_data_in[r] = (~red_alloc[r] & red_tag[r][0]) ? wr_data[dword_w-1:word_w]
                                                              : wr_data[word_w-1:0];

      always_ff @(posedge clk) begin
         if (!rst_n) begin
            red_valid[r] <= 1'b0;
         end else if (red_alloc[r]) begin
            red_valid[r] <= 1'b1;
         end
      end

      always_ff @(posedge clk) begin
         if (red_alloc[r]) begin
            red_tag[r] <= rw_addr.tag_view.tag;
         end
         if (red_alloc[r] | red_refresh[r]) begin
            red_data[r] <= red_data_in[r];
         end
      end

      //***********************************************************************
      // Tag match per bank, through either address
      //***********************************************************************
      for (genvar b = 0; b < num_banks; b++) begin : g_bank
         assign red_hit[r][b] = red_valid[r] &
            (((rw_addr.tag_view.tag == red_tag[r]) &
              (rw_addr.bank_view.bank == bank_idx_w'(b))) |
             ((addr_inc.tag_view.tag == red_tag[r]) &
              (addr_inc.bank_view.bank == bank_idx_w'(b))));
      end
   end

   // Flip after each correction, or point away from a row hit mid-correction
   assign lru_en = buf_correct_ecc | ((|red_hit) & rden & correction_state);
   assign lru_in = buf_correct_ecc ? ~red_lru : (|red_hit[0]);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         red_lru <= 1'b0;
      end else if (lru_en) begin
         red_lru <= lru_in;
      end
   end

   // Hit flags line up with the bank read data
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         red_hit_q <= '0;
      end else if (rden) begin
         red_hit_q <= red_hit;
      end
   end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
#
# Builds the ICCM testbench with Verilator, runs it and scans the log.
# Exits with 0 on a clean run and with 1 otherwise.

cd "$(dirname "$0")" || exit 1

log=sim.log
top=iccm_mem_tb

rm -f "$log"

verilator --binary --timing -j 0 --top-module "$top" -f iccm_mem.f -o "$top" \
   > "$log" 2>&1 \
   && ./obj_dir/"$top" >> "$log" 2>&1 \
   || { cat "$log"; echo "Build or simulation did not complete"; exit 1; }

cat "$log"

grep -q '\*\* FAIL \*\*' "$log" \
   && { echo "Simulation failed"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }
